/* logic/trap_pkg.sv */
// trap package: CSR map, interrupt cause codes and shared trap structures
`default_nettype none

package trap_pkg;

  localparam int xlen = 32;

  // standard machine CSRs
  localparam logic [11:0] csr_mstatus_addr = 12'h300;
  localparam logic [11:0] csr_mie_addr     = 12'h304;
  localparam logic [11:0] csr_mtvec_addr   = 12'h305;
  localparam logic [11:0] csr_mepc_addr    = 12'h341;
  localparam logic [11:0] csr_mcause_addr  = 12'h342;
  localparam logic [11:0] csr_mtval_addr   = 12'h343;
  localparam logic [11:0] csr_mip_addr     = 12'h344;

  // custom timer and interrupt controller registers
  localparam logic [11:0] csr_mtimecmp_lo_addr = 12'h7c0;
  localparam logic [11:0] csr_mtimecmp_hi_addr = 12'h7c1;
  localparam logic [11:0] csr_irq_mask_addr    = 12'h7c2;
  localparam logic [11:0] csr_mtime_lo_addr    = 12'h7c4;
  localparam logic [11:0] csr_mtime_hi_addr    = 12'h7c5;

  localparam logic [30:0] cause_timer = 31'd7;

  localparam int          ext_irq_lines   = 8;
  localparam int unsigned ext_irq_base_id = 16;

  // mie at bit 3, mpie at bit 7
  typedef struct packed {
    logic [23:0] rsvd_hi;
    logic        mpie;
    logic [2:0]  rsvd_mid;
    logic        mie;
    logic [2:0]  rsvd_lo;
  } mstatus_t;

  // meie at bit 11, mtie at bit 7
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        meie;
    logic [2:0]  rsvd_mid;
    logic        mtie;
    logic [6:0]  rsvd_lo;
  } mie_t;

  // same layout as mie
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        meip;
    logic [2:0]  rsvd_mid;
    logic        mtip;
    logic [6:0]  rsvd_lo;
  } mip_t;

  typedef struct packed {
    logic       occurred;
    logic [3:0] cause;
  } exc_cause_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [11:0]     addr;
    logic [xlen-1:0] wdata;
  } csr_req_t;

  typedef struct packed {
    logic            trap;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mtval;
  } trap_info_t;

endpackage

`default_nettype wire

/* logic/exception_ctrl.sv */
// exception controller: cause pipeline, interrupt qualification and trap target
`default_nettype none

module exception_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      stall_n,
  input  logic                      hold_flag,
  input  logic                      exception_if,
  input  logic                      exception_id,
  input  logic [3:0]                cause_if,
  input  logic [3:0]                cause_id,
  input  logic [trap_pkg::xlen-1:0] pc_id_ex,
  input  logic                      jump_en,
  input  logic [trap_pkg::xlen-1:0] jump_addr,
  input  trap_pkg::mstatus_t        csr_mstatus,
  input  trap_pkg::mie_t            csr_mie,
  input  logic [trap_pkg::xlen-1:0] csr_mtvec,
  input  logic                      mtip,
  input  logic                      meip,
  input  logic [30:0]               ext_id,
  output trap_pkg::trap_info_t      trap_info,
  output logic [trap_pkg::xlen-1:0] trap_target,
  output logic                      any_interrupt
);

  trap_pkg::exc_cause_t exc_if_id;
  trap_pkg::exc_cause_t exc_id_ex;
  trap_pkg::mip_t       mip;

  logic                      ext_req;
  logic                      timer_req;
  logic                      valid_req;
  logic [30:0]               req_cause;
  logic                      ready_interrupt;
  logic [30:0]               int_cause;
  logic                      int_taken;
  logic [30:0]               trap_code;
  logic [1:0]                jmp_pending;
  logic [trap_pkg::xlen-1:0] last_jump_addr;
  logic [trap_pkg::xlen-1:0] trap_base;

  // decode exception overrides whatever fetch sent down
  always_ff @(posedge clk) begin
    if (reset || hold_flag) begin
      exc_if_id <= '0;
      exc_id_ex <= '0;
    end else if (stall_n) begin
      exc_if_id <= {exception_if, cause_if};
      if (exception_id) begin
        exc_id_ex <= {1'b1, cause_id};
      end else begin
        exc_id_ex <= exc_if_id;
      end
    end
  end

  always_comb begin
    mip      = '0;
    mip.meip = meip;
    mip.mtip = mtip;
  end

  assign ext_req       = csr_mie.meie && mip.meip;
  assign timer_req     = csr_mie.mtie && mip.mtip;
  assign any_interrupt = ext_req || timer_req;

  // interrupts wait behind an exception already in ID/EX
  assign valid_req = any_interrupt && csr_mstatus.mie && !exc_id_ex.occurred;
  // external beats timer
  assign req_cause = ext_req ? ext_id : trap_pkg::cause_timer;

  // one-shot that clears the cycle after it fires
  always_ff @(posedge clk) begin
    if (reset) begin
      ready_interrupt <= 1'b0;
    end else if (ready_interrupt) begin
      ready_interrupt <= 1'b0;
    end else if (stall_n) begin
      ready_interrupt <= valid_req;
    end
  end

  always_ff @(posedge clk) begin
    if (stall_n && !ready_interrupt) begin
      int_cause <= req_cause;
    end
  end

  // jump target stays the return point for two cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      jmp_pending <= 2'b00;
    end else if (stall_n) begin
      if (jump_en) begin
        jmp_pending <= 2'b11;
      end else begin
        jmp_pending <= {jmp_pending[0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (stall_n && jump_en) begin
      last_jump_addr <= jump_addr;
    end
  end

  assign int_taken = ready_interrupt && !exc_id_ex.occurred;
  assign trap_code = int_taken ? int_cause : {27'd0, exc_id_ex.cause};

  assign trap_info.trap   = int_taken || exc_id_ex.occurred;
  assign trap_info.mepc   = jmp_pending[1] ? last_jump_addr : pc_id_ex;
  assign trap_info.mcause = {int_taken, trap_code};
  assign trap_info.mtval  = '0;

  // vectored mode only offsets interrupts
  assign trap_base = {csr_mtvec[31:2], 2'b00};
  always_comb begin
    trap_target = trap_base;
    if (int_taken && csr_mtvec[1:0] == 2'b01) begin
      trap_target = trap_base + {trap_code[29:0], 2'b00};
    end
  end

  // MIE is cleared on entry, so a level interrupt traps only once
  interrupt_one_shot: assert property (
    @(posedge clk) disable iff (reset) int_taken |=> !int_taken && !csr_mstatus.mie
  );

  pc_known_on_trap: assert property (
    @(posedge clk) disable iff (reset) trap_info.trap |-> !$isunknown(pc_id_ex)
  );

endmodule

`default_nettype wire

/* logic/trap_csr_file.sv */
// machine CSR file: trap entry and mret updates, software access, read merge
`default_nettype none

module trap_csr_file (
  input  logic                      clk,
  input  logic                      reset,
  input  trap_pkg::csr_req_t        csr_req,
  input  trap_pkg::trap_info_t      trap_info,
  input  logic                      mret,
  input  logic                      mtip,
  input  logic                      meip,
  input  logic [trap_pkg::xlen-1:0] timer_rdata,
  input  logic [trap_pkg::xlen-1:0] irq_rdata,
  output trap_pkg::mstatus_t        csr_mstatus,
  output trap_pkg::mie_t            csr_mie,
  output logic [trap_pkg::xlen-1:0] csr_mtvec,
  output logic [trap_pkg::xlen-1:0] csr_rdata
);

  trap_pkg::mstatus_t wr_status;
  trap_pkg::mie_t     wr_enable;
  trap_pkg::mip_t     mip;

  logic                      csr_wr;
  logic [trap_pkg::xlen-1:0] mepc;
  logic [trap_pkg::xlen-1:0] mcause;
  logic [trap_pkg::xlen-1:0] mtval;
  logic [trap_pkg::xlen-1:0] local_rdata;

  assign csr_wr    = csr_req.valid && csr_req.write;
  assign wr_status = trap_pkg::mstatus_t'(csr_req.wdata);
  assign wr_enable = trap_pkg::mie_t'(csr_req.wdata);

  // trap entry overrides a software write in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      csr_mstatus <= '0;
      csr_mie     <= '0;
      csr_mtvec   <= '0;
      mepc        <= '0;
    end else begin
      if (csr_wr) begin
        case (csr_req.addr)
          trap_pkg::csr_mstatus_addr: begin
            csr_mstatus.mie  <= wr_status.mie;
            csr_mstatus.mpie <= wr_status.mpie;
          end
          trap_pkg::csr_mie_addr: begin
            csr_mie.meie <= wr_enable.meie;
            csr_mie.mtie <= wr_enable.mtie;
          end
          trap_pkg::csr_mtvec_addr: csr_mtvec <= csr_req.wdata;
          trap_pkg::csr_mepc_addr:  mepc <= {csr_req.wdata[31:2], 2'b00};
          default: ;
        endcase
      end
      if (trap_info.trap) begin
        mepc             <= trap_info.mepc;
        csr_mstatus.mpie <= csr_mstatus.mie;
        csr_mstatus.mie  <= 1'b0;
      end else if (mret) begin
        csr_mstatus.mie  <= csr_mstatus.mpie;
        csr_mstatus.mpie <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (trap_info.trap) begin
      mcause <= trap_info.mcause;
      mtval  <= trap_info.mtval;
    end else if (csr_wr) begin
      if (csr_req.addr == trap_pkg::csr_mcause_addr) begin
        mcause <= csr_req.wdata;
      end
      if (csr_req.addr == trap_pkg::csr_mtval_addr) begin
        mtval <= csr_req.wdata;
      end
    end
  end

  // pending bits come live from the timer and irq controller
  always_comb begin
    mip      = '0;
    mip.meip = meip;
    mip.mtip = mtip;
  end

  always_comb begin
    local_rdata = '0;
    if (csr_req.valid) begin
      case (csr_req.addr)
        trap_pkg::csr_mstatus_addr: local_rdata = csr_mstatus;
        trap_pkg::csr_mie_addr:     local_rdata = csr_mie;
        trap_pkg::csr_mtvec_addr:   local_rdata = csr_mtvec;
        trap_pkg::csr_mepc_addr:    local_rdata = mepc;
        trap_pkg::csr_mcause_addr:  local_rdata = mcause;
        trap_pkg::csr_mtval_addr:   local_rdata = mtval;
        trap_pkg::csr_mip_addr:     local_rdata = mip;
        default:                    local_rdata = '0;
      endcase
    end
  end

  // peers return zero outside their own addresses
  assign csr_rdata = local_rdata | timer_rdata | irq_rdata;

  trap_mret_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(trap_info.trap && mret)
  );

endmodule

`default_nettype wire

/* logic/machine_timer.sv */
// machine timer: free-running mtime, mtimecmp register and pending level
`default_nettype none

module machine_timer (
  input  logic                      clk,
  input  logic                      reset,
  input  trap_pkg::csr_req_t        csr_req,
  output logic                      mtip,
  output logic [trap_pkg::xlen-1:0] timer_rdata
);

  logic        csr_wr;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;

  assign csr_wr = csr_req.valid && csr_req.write;

  always_ff @(posedge clk) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // all ones keeps the timer quiet until software programs it
  always_ff @(posedge clk) begin
    if (reset) begin
      mtimecmp <= '1;
    end else if (csr_wr) begin
      if (csr_req.addr == trap_pkg::csr_mtimecmp_lo_addr) begin
        mtimecmp[31:0] <= csr_req.wdata;
      end
      if (csr_req.addr == trap_pkg::csr_mtimecmp_hi_addr) begin
        mtimecmp[63:32] <= csr_req.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mtip <= 1'b0;
    end else begin
      mtip <= (mtime >= mtimecmp);
    end
  end

  always_comb begin
    timer_rdata = '0;
    if (csr_req.valid) begin
      case (csr_req.addr)
        trap_pkg::csr_mtimecmp_lo_addr: timer_rdata = mtimecmp[31:0];
        trap_pkg::csr_mtimecmp_hi_addr: timer_rdata = mtimecmp[63:32];
        trap_pkg::csr_mtime_lo_addr:    timer_rdata = mtime[31:0];
        trap_pkg::csr_mtime_hi_addr:    timer_rdata = mtime[63:32];
        default:                        timer_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/ext_irq_ctrl.sv */
// external interrupt controller: enable mask and fixed-priority claim over eight lines
`default_nettype none

module ext_irq_ctrl (
  input  logic                               clk,
  input  logic                               reset,
  input  trap_pkg::csr_req_t                 csr_req,
  input  logic [trap_pkg::ext_irq_lines-1:0] irq_lines,
  output logic                               meip,
  output logic [30:0]                        ext_id,
  output logic [trap_pkg::xlen-1:0]          irq_rdata
);

  logic [trap_pkg::ext_irq_lines-1:0] mask;
  logic [trap_pkg::ext_irq_lines-1:0] pending;
  logic [trap_pkg::ext_irq_lines-1:0] lowest_hit;
  logic                               mask_wr;

  assign mask_wr = csr_req.valid && csr_req.write &&
                   csr_req.addr == trap_pkg::csr_irq_mask_addr;

  always_ff @(posedge clk) begin
    if (reset) begin
      mask <= '0;
    end else if (mask_wr) begin
      mask <= csr_req.wdata[trap_pkg::ext_irq_lines-1:0];
    end
  end

  assign pending = irq_lines & mask;
  assign meip    = |pending;

  // walk down so the lowest line is the one left standing
  always_comb begin
    ext_id = '0;
    for (int i = trap_pkg::ext_irq_lines - 1; i >= 0; i--) begin
      if (pending[i]) begin
        ext_id = 31'(trap_pkg::ext_irq_base_id + i);
      end
    end
  end

  // two's complement isolates the lowest pending line
  assign lowest_hit = pending & -pending;

  always_comb begin
    irq_rdata = '0;
    if (csr_req.valid && csr_req.addr == trap_pkg::csr_irq_mask_addr) begin
      irq_rdata[trap_pkg::ext_irq_lines-1:0] = mask;
    end
  end

  // claimed id must name the lowest enabled asserted line
  claim_id_in_range: assert property (
    @(posedge clk) disable iff (reset)
      meip |-> ext_id >= 31'(trap_pkg::ext_irq_base_id) &&
               (lowest_hit >> (ext_id - 31'(trap_pkg::ext_irq_base_id))) == 1
  );

endmodule

`default_nettype wire

/* logic/trap_unit.sv */
// trap unit top: exception controller, CSR file, timer and external interrupt controller
`default_nettype none

module trap_unit (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               stall_n,
  input  logic                               hold_flag,
  input  logic                               exception_if,
  input  logic [3:0]                         cause_if,
  input  logic                               exception_id,
  input  logic [3:0]                         cause_id,
  input  logic [trap_pkg::xlen-1:0]          pc_id_ex,
  input  logic                               jump_en,
  input  logic [trap_pkg::xlen-1:0]          jump_addr,
  input  trap_pkg::csr_req_t                 csr_req,
  input  logic                               mret,
  input  logic [trap_pkg::ext_irq_lines-1:0] irq_lines,
  output logic [trap_pkg::xlen-1:0]          csr_rdata,
  output logic                               trap_taken,
  output logic [trap_pkg::xlen-1:0]          trap_target,
  output logic                               any_interrupt
);

  trap_pkg::trap_info_t trap_info;
  trap_pkg::mstatus_t   csr_mstatus;
  trap_pkg::mie_t       csr_mie;

  logic [trap_pkg::xlen-1:0] csr_mtvec;
  logic                      mtip;
  logic                      meip;
  logic [30:0]               ext_id;
  logic [trap_pkg::xlen-1:0] timer_rdata;
  logic [trap_pkg::xlen-1:0] irq_rdata;

  assign trap_taken = trap_info.trap;

  exception_ctrl exception_ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .stall_n       (stall_n),
    .hold_flag     (hold_flag),
    .exception_if  (exception_if),
    .exception_id  (exception_id),
    .cause_if      (cause_if),
    .cause_id      (cause_id),
    .pc_id_ex      (pc_id_ex),
    .jump_en       (jump_en),
    .jump_addr     (jump_addr),
    .csr_mstatus   (csr_mstatus),
    .csr_mie       (csr_mie),
    .csr_mtvec     (csr_mtvec),
    .mtip          (mtip),
    .meip          (meip),
    .ext_id        (ext_id),
    .trap_info     (trap_info),
    .trap_target   (trap_target),
    .any_interrupt (any_interrupt)
  );

  trap_csr_file trap_csr_file_i (
    .clk         (clk),
    .reset       (reset),
    .csr_req     (csr_req),
    .trap_info   (trap_info),
    .mret        (mret),
    .mtip        (mtip),
    .meip        (meip),
    .timer_rdata (timer_rdata),
    .irq_rdata   (irq_rdata),
    .csr_mstatus (csr_mstatus),
    .csr_mie     (csr_mie),
    .csr_mtvec   (csr_mtvec),
    .csr_rdata   (csr_rdata)
  );

  machine_timer machine_timer_i (
    .clk         (clk),
    .reset       (reset),
    .csr_req     (csr_req),
    .mtip        (mtip),
    .timer_rdata (timer_rdata)
  );

  ext_irq_ctrl ext_irq_ctrl_i (
    .clk       (clk),
    .reset     (reset),
    .csr_req   (csr_req),
    .irq_lines (irq_lines),
    .meip      (meip),
    .ext_id    (ext_id),
    .irq_rdata (irq_rdata)
  );

endmodule

`default_nettype wire

/* tests/trap_unit_tb.sv */
// trap unit testbench: directed tests of exceptions, jumps, timer and external interrupts
`default_nettype none

module trap_unit_tb;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int ext_rounds   = 8;
  localparam int stall_len    = 3;

  // rough length of each test in cycles, used by the watchdog
  localparam int exc_cycles    = 80;
  localparam int jump_cycles   = 40;
  localparam int timer_cycles  = 120;
  localparam int ext_cycles    = ext_rounds * 20 + 40;
  localparam int gate_cycles   = 60;
  localparam int margin_cycles = 200;
  localparam int run_cycles    = reset_cycles + exc_cycles + jump_cycles + timer_cycles +
                                 ext_cycles + gate_cycles + margin_cycles;

  localparam logic [31:0] pc_value  = 32'h0000_1040;
  localparam logic [31:0] vec_base  = 32'h0000_0200;
  localparam logic [31:0] mie_bit   = 32'h0000_0008;
  localparam logic [31:0] mtie_bit  = 32'h0000_0080;
  localparam logic [31:0] meie_bit  = 32'h0000_0800;

  logic                      clk;
  logic                      reset;
  logic                      stall_n;
  logic                      hold_flag;
  logic                      exception_if;
  logic [3:0]                cause_if;
  logic                      exception_id;
  logic [3:0]                cause_id;
  logic [31:0]               pc_id_ex;
  logic                      jump_en;
  logic [31:0]               jump_addr;
  trap_pkg::csr_req_t        csr_req;
  logic                      mret;
  logic [7:0]                irq_lines;
  logic [31:0]               csr_rdata;
  logic                      trap_taken;
  logic [31:0]               trap_target;
  logic                      any_interrupt;

  int          errors = 0;
  int          checks = 0;
  int          trap_count = 0;
  int          cycles = 0;
  int          last_trap_cycle = 0;
  logic [31:0] last_trap_target = '0;
  integer      seed;

  trap_unit dut_i (
    .clk           (clk),
    .reset         (reset),
    .stall_n       (stall_n),
    .hold_flag     (hold_flag),
    .exception_if  (exception_if),
    .cause_if      (cause_if),
    .exception_id  (exception_id),
    .cause_id      (cause_id),
    .pc_id_ex      (pc_id_ex),
    .jump_en       (jump_en),
    .jump_addr     (jump_addr),
    .csr_req       (csr_req),
    .mret          (mret),
    .irq_lines     (irq_lines),
    .csr_rdata     (csr_rdata),
    .trap_taken    (trap_taken),
    .trap_target   (trap_target),
    .any_interrupt (any_interrupt)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // trap counter and a record of the latest trap sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && trap_taken === 1'b1) begin
      trap_count++;
      last_trap_cycle = cycles;
      last_trap_target = trap_target;
    end
    cycles++;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("at time %0t: %s", $time, what);
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - err0);
    end
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
  endtask

  // all tasks start and end just after a rising edge
  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    csr_req <= {1'b1, 1'b1, addr, data};
    @(posedge clk);
    csr_req <= '0;
  endtask

  task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
    csr_req <= {1'b1, 1'b0, addr, 32'd0};
    @(negedge clk);
    data = csr_rdata;
    @(posedge clk);
    csr_req <= '0;
  endtask

  task automatic wait_trap(input int limit, output bit seen);
    int start;
    int n;
    start = trap_count;
    n = 0;
    while (trap_count == start && n < limit) begin
      @(posedge clk);
      n++;
    end
    seen = (trap_count != start);
  endtask

  // lowest numbered enabled and asserted line wins
  function automatic int lowest_cause(input logic [7:0] lines, input logic [7:0] mask);
    logic [7:0] hits;
    int         code;
    int         i;
    hits = lines & mask;
    code = -1;
    i = 0;
    while (code < 0 && i < 8) begin
      if (hits[i]) begin
        code = int'(trap_pkg::ext_irq_base_id) + i;
      end
      i++;
    end
    return code;
  endfunction

  task automatic test_exceptions();
    int          err0;
    int          c0;
    int          t0;
    bit          seen;
    logic [31:0] rd;
    err0 = errors;
    // decode exception traps one cycle later
    c0 = cycles;
    exception_id <= 1'b1;
    cause_id     <= 4'd2;
    @(posedge clk);
    exception_id <= 1'b0;
    wait_trap(10, seen);
    check_true(seen, "no trap was taken after the decode exception");
    check_value("decode trap latency", last_trap_cycle - c0, 1);
    csr_read(trap_pkg::csr_mcause_addr, rd);
    check_value("mcause", rd, 32'd2);
    csr_read(trap_pkg::csr_mepc_addr, rd);
    check_value("mepc", rd, pc_value);
    // fetch exception travels two stages
    c0 = cycles;
    exception_if <= 1'b1;
    cause_if     <= 4'd5;
    @(posedge clk);
    exception_if <= 1'b0;
    wait_trap(10, seen);
    check_true(seen, "no trap was taken after the fetch exception");
    check_value("fetch trap latency", last_trap_cycle - c0, 2);
    csr_read(trap_pkg::csr_mcause_addr, rd);
    check_value("mcause", rd, 32'd5);
    // a stall stretches the latency by its length
    c0 = cycles;
    t0 = trap_count;
    exception_if <= 1'b1;
    @(posedge clk);
    exception_if <= 1'b0;
    stall_n      <= 1'b0;
    settle(stall_len);
    stall_n <= 1'b1;
    wait_trap(10, seen);
    check_true(seen, "no trap was taken after the stalled fetch exception");
    check_value("stalled trap latency", last_trap_cycle - c0, 2 + stall_len);
    settle(4);
    check_value("traps around stall", trap_count - t0, 1);
    // flush drops the fetch exception
    t0 = trap_count;
    exception_if <= 1'b1;
    @(posedge clk);
    exception_if <= 1'b0;
    hold_flag    <= 1'b1;
    @(posedge clk);
    hold_flag <= 1'b0;
    settle(6);
    check_value("traps after hold_flag", trap_count - t0, 0);
    report_test("exceptions", err0);
  endtask

  task automatic jump_then_trap(input int gap);
    logic [31:0] target;
    logic [31:0] expected;
    logic [31:0] rd;
    bit          seen;
    target = 32'h0000_2000 + gap * 16;
    // the jump target is the return point for two cycles after the jump
    expected = (gap < 2) ? target : pc_value;
    jump_en   <= 1'b1;
    jump_addr <= target;
    repeat (gap) begin
      @(posedge clk);
      jump_en <= 1'b0;
    end
    exception_id <= 1'b1;
    cause_id     <= 4'd1;
    @(posedge clk);
    jump_en      <= 1'b0;
    exception_id <= 1'b0;
    wait_trap(10, seen);
    check_true(seen, "no trap was taken after the exception following a jump");
    csr_read(trap_pkg::csr_mepc_addr, rd);
    check_value("mepc", rd, expected);
  endtask

  task automatic test_jump();
    int err0;
    err0 = errors;
    jump_then_trap(1);
    jump_then_trap(3);
    report_test("jump in flight", err0);
  endtask

  task automatic test_timer();
    int          err0;
    int          t0;
    bit          seen;
    logic [31:0] now;
    logic [31:0] rd;
    err0 = errors;
    csr_read(trap_pkg::csr_mtime_lo_addr, now);
    csr_write(trap_pkg::csr_mtimecmp_hi_addr, 32'd0);
    csr_write(trap_pkg::csr_mtimecmp_lo_addr, now + 32'd20);
    csr_write(trap_pkg::csr_mtvec_addr, 32'h0000_0100);
    csr_write(trap_pkg::csr_mie_addr, mtie_bit);
    t0 = trap_count;
    csr_write(trap_pkg::csr_mstatus_addr, mie_bit);
    wait_trap(60, seen);
    check_true(seen, "the timer interrupt was not taken");
    check_value("trap_target", last_trap_target, 32'h0000_0100);
    csr_read(trap_pkg::csr_mcause_addr, rd);
    check_value("mcause", rd, 32'h8000_0007);
    csr_read(trap_pkg::csr_mstatus_addr, rd);
    check_value("mstatus after trap", rd, 32'h0000_0080);
    // quiet the timer before returning
    csr_write(trap_pkg::csr_mtimecmp_hi_addr, 32'hffff_ffff);
    settle(4);
    check_value("timer traps", trap_count - t0, 1);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    csr_read(trap_pkg::csr_mstatus_addr, rd);
    check_value("mstatus after mret", rd, 32'h0000_0088);
    settle(4);
    check_value("timer traps after mret", trap_count - t0, 1);
    csr_write(trap_pkg::csr_mstatus_addr, 32'd0);
    csr_write(trap_pkg::csr_mie_addr, 32'd0);
    report_test("timer interrupt", err0);
  endtask

  task automatic test_external();
    int          err0;
    int          idx;
    int          cause;
    bit          seen;
    logic [7:0]  lines;
    logic [7:0]  mask;
    logic [31:0] rd;
    err0 = errors;
    csr_write(trap_pkg::csr_mtvec_addr, vec_base | 32'd1);
    csr_write(trap_pkg::csr_mie_addr, meie_bit);
    for (int r = 0; r < ext_rounds; r++) begin
      lines = 8'($random(seed));
      mask  = 8'($random(seed));
      idx   = $random(seed) & 7;
      // keep at least one enabled line asserted
      lines[idx] = 1'b1;
      mask[idx]  = 1'b1;
      cause = lowest_cause(lines, mask);
      csr_write(trap_pkg::csr_irq_mask_addr, {24'd0, mask});
      irq_lines <= lines;
      csr_write(trap_pkg::csr_mstatus_addr, mie_bit);
      wait_trap(10, seen);
      check_true(seen, "the external interrupt was not taken");
      check_value("trap_target", last_trap_target, vec_base + 4 * cause);
      csr_read(trap_pkg::csr_mcause_addr, rd);
      check_value("mcause", rd, 32'h8000_0000 | cause);
      irq_lines <= '0;
      settle(2);
    end
    // external and timer pending together
    csr_write(trap_pkg::csr_irq_mask_addr, 32'h0000_00ff);
    csr_write(trap_pkg::csr_mie_addr, meie_bit | mtie_bit);
    csr_write(trap_pkg::csr_mtimecmp_lo_addr, 32'd0);
    csr_write(trap_pkg::csr_mtimecmp_hi_addr, 32'd0);
    settle(2);
    check_value("any_interrupt", {31'd0, any_interrupt}, 32'd1);
    irq_lines <= 8'h30;
    csr_write(trap_pkg::csr_mstatus_addr, mie_bit);
    wait_trap(10, seen);
    check_true(seen, "no interrupt was taken with timer and external pending");
    check_value("trap_target", last_trap_target, vec_base + 32'd80);
    csr_read(trap_pkg::csr_mcause_addr, rd);
    check_value("mcause", rd, 32'h8000_0014);
    irq_lines <= '0;
    report_test("external interrupts", err0);
  endtask

  // timer is still pending from the external test
  task automatic test_gating();
    int          err0;
    int          t0;
    bit          seen;
    logic [31:0] rd;
    err0 = errors;
    t0 = trap_count;
    settle(1);
    check_value("any_interrupt", {31'd0, any_interrupt}, 32'd1);
    settle(10);
    check_value("traps with MIE clear", trap_count - t0, 0);
    // exception reaches ID/EX as MIE comes on
    csr_req      <= {1'b1, 1'b1, trap_pkg::csr_mstatus_addr, mie_bit};
    exception_id <= 1'b1;
    cause_id     <= 4'd3;
    @(posedge clk);
    csr_req      <= '0;
    exception_id <= 1'b0;
    wait_trap(10, seen);
    check_true(seen, "no trap was taken for the exception in ID/EX");
    check_value("trap_target", last_trap_target, vec_base);
    csr_read(trap_pkg::csr_mcause_addr, rd);
    check_value("mcause", rd, 32'd3);
    settle(6);
    check_value("traps for exception", trap_count - t0, 1);
    csr_write(trap_pkg::csr_mtimecmp_hi_addr, 32'hffff_ffff);
    csr_write(trap_pkg::csr_mie_addr, 32'd0);
    csr_write(trap_pkg::csr_mstatus_addr, 32'd0);
    report_test("gating", err0);
  endtask

  initial begin
    seed = 32'h70b9_e822;
    reset = 1'b1;
    stall_n = 1'b1;
    hold_flag = 1'b0;
    exception_if = 1'b0;
    cause_if = 4'd0;
    exception_id = 1'b0;
    cause_id = 4'd0;
    pc_id_ex = pc_value;
    jump_en = 1'b0;
    jump_addr = 32'd0;
    csr_req = '0;
    mret = 1'b0;
    irq_lines = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_exceptions();
    test_jump();
    test_timer();
    test_external();
    test_gating();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    #(run_cycles * clk_period);
    $display("watchdog: the run did not finish within %0d cycles", run_cycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/trap_pkg.sv
logic/exception_ctrl.sv
logic/trap_csr_file.sv
logic/machine_timer.sv
logic/ext_irq_ctrl.sv
logic/trap_unit.sv
tests/trap_unit_tb.sv
